// ==== Makefile ====
VERILATOR ?= verilator
SEED      ?= 46225
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
TOP       := tb_cpu
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard common/*.sv verilog/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sources.f
	$(VERILATOR) --binary --timing --assert -f sources.f --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	// instruction port address, counted in words
	typedef logic [9:0] pc_t;

	// primary opcode, bits 30:25
	typedef enum logic [5:0] {
		op_alu_r = 6'b100000,
		op_addi  = 6'b101000,
		op_ori   = 6'b101100,
		op_movi  = 6'b100010,
		op_lwi   = 6'b000010,
		op_swi   = 6'b001010,
		op_beq   = 6'b100110,
		op_bne   = 6'b100111,
		op_j     = 6'b100100
	} opcode_t;

	typedef enum logic [4:0] {
		fn_add  = 5'b00000,
		fn_sub  = 5'b00001,
		fn_and  = 5'b00010,
		fn_xor  = 5'b00011,
		fn_or   = 5'b00100,
		fn_slli = 5'b01000,
		fn_srli = 5'b01001
	} alu_fn_t;

	// shift amount of slli and srli sits in the rb field
	typedef struct packed {
		logic       spare;
		opcode_t    opcode;
		reg_addr_t  rt;
		reg_addr_t  ra;
		reg_addr_t  rb;
		logic [4:0] spare_lo;
		alu_fn_t    fn;
	} r_format_t;

	typedef struct packed {
		logic        spare;
		opcode_t     opcode;
		reg_addr_t   rt;
		reg_addr_t   ra;
		logic [14:0] imm;
	} i_format_t;

	// movi uses bits 19:0, j uses bits 23:0 of the same word
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_u;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_sll    = 3'd5,
		alu_srl    = 3'd6,
		alu_pass_b = 3'd7
	} alu_op_t;

	typedef struct packed {
		alu_op_t            alu_op;
		logic               use_imm;
		logic               mem_read;
		logic               mem_write;
		logic               reg_write;
		isa_pkg::reg_addr_t dest;
	} ctrl_t;

	// bubble, no memory access and no write
	localparam ctrl_t ctrl_nop = '0;

	typedef struct packed {
		ctrl_t                    ctrl;
		logic [isa_pkg::xlen-1:0] ra_value;
		logic [isa_pkg::xlen-1:0] rb_value;
		logic [isa_pkg::xlen-1:0] rt_value;
		logic [isa_pkg::xlen-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                    ctrl;
		logic [isa_pkg::xlen-1:0] result;
		logic [isa_pkg::xlen-1:0] store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                     reg_write;
		isa_pkg::reg_addr_t       dest;
		logic [isa_pkg::xlen-1:0] data;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== sources.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/forward.sv
verilog/decoder.sv
verilog/fetch.sv
verilog/cpu_top.sv
verif/cpu_asserts.sv
verif/tb_cpu.sv

// ==== verif/cpu_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_asserts (
	input wire               clk,
	input wire               reset,
	input wire               im_read,
	input wire isa_pkg::pc_t im_address,
	input wire               dm_read,
	input wire               dm_write,
	input wire [11:0]        dm_address
);

	// memory ports stay quiet through reset
	reset_quiet: assert property (@(posedge clk)
		reset && $past(reset) |-> !dm_read && !dm_write && !im_read)
		else $error("memory strobes active during reset");

	first_cycle: assert property (@(posedge clk)
		$fell(reset) |-> !dm_read && !dm_write && !im_read && im_address == '0)
		else $error("bad state in first cycle after reset");

	// a stalled fetch keeps its address
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		!im_read |=> $stable(im_address))
		else $error("im_address moved while fetch was stalled");

	rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high together");

	addr_known: assert property (@(posedge clk) disable iff (reset)
		(dm_read || dm_write) |-> !$isunknown(dm_address))
		else $error("dm_address unknown during an access");

endmodule

bind cpu_top cpu_asserts u_cpu_asserts (.*);

`default_nettype wire

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu #(
	parameter int SEED = 46225
);
	import isa_pkg::*;

	logic        clk;
	logic        reset;
	logic [31:0] instruction;
	logic        alu_overflow;
	logic        im_read;
	pc_t         im_address;
	logic        dm_read;
	logic        dm_write;
	logic [11:0] dm_address;
	logic [31:0] dm_wdata;
	logic [31:0] dm_rdata;

	logic [31:0] imem [1024];
	logic [31:0] dmem [4096];
	logic [31:0] model_mem [4096];
	logic [31:0] model_reg [32];
	logic [11:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [11:0] load_exp [$];
	int          ovf_exp [$];
	int          prog_len;
	int          store_seen;
	int          load_seen;
	int          ovf_seen;
	int          errors;
	bit          prog_ready;

	cpu_top i_cpu_top (.*);

	assign instruction = imem[im_address];
	assign dm_rdata = dmem[dm_address];

	always @(posedge clk) begin
		if (dm_write)
			dmem[dm_address] <= dm_wdata;
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(alu_fn_t fn, reg_addr_t rt, reg_addr_t ra,
		reg_addr_t rb);
		return {1'b0, op_alu_r, rt, ra, rb, 5'b0, fn};
	endfunction

	function automatic logic [31:0] enc_i(opcode_t op, reg_addr_t rt, reg_addr_t ra,
		logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic emit_movi(input reg_addr_t rt, input logic [19:0] imm);
		emit({1'b0, op_movi, rt, imm});
	endtask

	task automatic emit_j(input logic [23:0] off);
		emit({1'b0, op_j, 1'b0, off});
	endtask

	// sequential run of the program, one instruction per step
	task automatic run_model();
		int          pc;
		int          steps;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		longint      wide;
		logic [11:0] addr;
		logic        ovf;
		logic        wr;
		logic        taken;
		pc = 0;
		for (steps = 0; steps < 1000; steps++) begin
			w = imem[pc];
			a = model_reg[w[19:15]];
			ovf = 1'b0;
			wr = 1'b0;
			taken = 1'b0;
			res = '0;
			case (opcode_t'(w[30:25]))
				op_alu_r: begin
					b = model_reg[w[14:10]];
					wr = 1'b1;
					case (alu_fn_t'(w[4:0]))
						fn_add: begin
							res = a + b;
							// true sum does not fit in 32 signed bits
							wide = longint'($signed(a)) + longint'($signed(b));
							ovf = (wide != longint'($signed(res)));
						end
						fn_sub: begin
							res = a - b;
							wide = longint'($signed(a)) - longint'($signed(b));
							ovf = (wide != longint'($signed(res)));
						end
						fn_and:  res = a & b;
						fn_or:   res = a | b;
						fn_xor:  res = a ^ b;
						fn_slli: res = a << w[14:10];
						fn_srli: res = a >> w[14:10];
						default: wr = 1'b0;
					endcase
				end
				op_addi: begin
					b = {{17{w[14]}}, w[14:0]};
					res = a + b;
					wide = longint'($signed(a)) + longint'($signed(b));
					ovf = (wide != longint'($signed(res)));
					wr = 1'b1;
				end
				op_ori: begin
					res = a | {17'b0, w[14:0]};
					wr = 1'b1;
				end
				op_movi: begin
					res = {{12{w[19]}}, w[19:0]};
					wr = 1'b1;
				end
				op_lwi: begin
					addr = 12'(a + {{17{w[14]}}, w[14:0]});
					res = model_mem[addr];
					load_exp.push_back(addr);
					wr = 1'b1;
				end
				op_swi: begin
					addr = 12'(a + {{17{w[14]}}, w[14:0]});
					model_mem[addr] = model_reg[w[24:20]];
					exp_addr.push_back(addr);
					exp_data.push_back(model_reg[w[24:20]]);
				end
				op_beq: taken = (a == model_reg[w[24:20]]);
				op_bne: taken = (a != model_reg[w[24:20]]);
				op_j: begin
					// a jump to itself ends the program
					if (w[23:0] == '0)
						break;
					taken = 1'b1;
				end
				default: ;
			endcase
			if (ovf)
				ovf_exp.push_back(exp_addr.size());
			if (wr && w[24:20] != 5'd0)
				model_reg[w[24:20]] = res;
			if (taken && opcode_t'(w[30:25]) == op_j)
				pc = int'(10'(pc + int'(w[23:0])));
			else if (taken)
				pc = int'(10'(pc + {{18{w[13]}}, w[13:0]}));
			else
				pc = pc + 1;
		end
	endtask

	task automatic build_program();
		emit_movi(5'd1, 20'($urandom()));
		emit_movi(5'd2, 20'($urandom()));
		emit(enc_r(fn_add, 5'd3, 5'd1, 5'd2));
		emit(enc_i(op_swi, 5'd3, 5'd0, 15'd16));
		emit(enc_r(fn_sub, 5'd4, 5'd3, 5'd1));
		emit(enc_r(fn_and, 5'd5, 5'd4, 5'd2));
		emit(enc_i(op_swi, 5'd4, 5'd0, 15'd17));
		emit(enc_r(fn_or, 5'd6, 5'd5, 5'd3));
		emit(enc_i(op_swi, 5'd5, 5'd0, 15'd18));
		emit(enc_r(fn_xor, 5'd7, 5'd6, 5'd1));
		emit(enc_i(op_swi, 5'd6, 5'd0, 15'd19));
		emit(enc_r(fn_slli, 5'd8, 5'd7, 5'd5));
		emit(enc_r(fn_srli, 5'd9, 5'd8, 5'd3));
		emit(enc_i(op_addi, 5'd10, 5'd9, 15'h7ff9));
		emit(enc_i(op_ori, 5'd11, 5'd9, 15'h7ff0));
		for (int r = 7; r <= 11; r++)
			emit(enc_i(op_swi, reg_addr_t'(r), 5'd0, 15'(13 + r)));
		// load-use pairs
		emit(enc_i(op_lwi, 5'd12, 5'd0, 15'd100));
		emit(enc_r(fn_add, 5'd13, 5'd12, 5'd1));
		emit(enc_i(op_swi, 5'd13, 5'd0, 15'd25));
		emit(enc_i(op_swi, 5'd3, 5'd0, 15'd50));
		emit(enc_i(op_lwi, 5'd15, 5'd0, 15'd50));
		emit(enc_i(op_swi, 5'd15, 5'd0, 15'd26));
		// branches and jump
		emit_movi(5'd20, 20'd5);
		emit_movi(5'd21, 20'd5);
		emit(enc_i(op_beq, 5'd21, 5'd20, 15'd3));
		emit(enc_i(op_swi, 5'd20, 5'd0, 15'd60));
		emit(enc_i(op_swi, 5'd21, 5'd0, 15'd61));
		emit(enc_i(op_bne, 5'd21, 5'd20, 15'd2));
		emit(enc_i(op_swi, 5'd20, 5'd0, 15'd62));
		emit(enc_i(op_bne, 5'd1, 5'd20, 15'd2));
		emit(enc_i(op_swi, 5'd20, 5'd0, 15'd63));
		emit(enc_i(op_beq, 5'd1, 5'd20, 15'd2));
		emit(enc_i(op_swi, 5'd21, 5'd0, 15'd64));
		emit_j(24'd2);
		emit(enc_i(op_swi, 5'd20, 5'd0, 15'd65));
		emit(enc_i(op_swi, 5'd21, 5'd0, 15'd66));
		// signed overflow on add and sub
		emit_movi(5'd22, 20'h7ffff);
		emit(enc_r(fn_slli, 5'd22, 5'd22, 5'd12));
		emit(enc_r(fn_add, 5'd23, 5'd22, 5'd22));
		emit(enc_i(op_swi, 5'd23, 5'd0, 15'd27));
		emit_movi(5'd24, 20'h80000);
		emit(enc_r(fn_slli, 5'd24, 5'd24, 5'd12));
		emit(enc_r(fn_sub, 5'd25, 5'd24, 5'd20));
		emit(enc_i(op_swi, 5'd25, 5'd0, 15'd28));
		emit_j(24'd0);
	endtask

	always @(negedge clk) begin
		if (!reset && dm_write) begin
			if (store_seen >= exp_addr.size()) begin
				errors++;
				$display("unexpected store at time %0t to address %0d", $time, dm_address);
			end else begin
				assert (dm_address == exp_addr[store_seen]) else begin
					errors++;
					$display("FAILED time %0t dm_address expected %0h actual %0h",
						$time, exp_addr[store_seen], dm_address);
				end
				assert (dm_wdata == exp_data[store_seen]) else begin
					errors++;
					$display("FAILED time %0t dm_wdata expected %0h actual %0h",
						$time, exp_data[store_seen], dm_wdata);
				end
			end
			store_seen++;
		end
		if (!reset && dm_read) begin
			if (load_seen >= load_exp.size()) begin
				errors++;
				$display("unexpected load at time %0t from address %0d", $time, dm_address);
			end else begin
				assert (dm_address == load_exp[load_seen]) else begin
					errors++;
					$display("FAILED time %0t dm_address expected %0h actual %0h",
						$time, load_exp[load_seen], dm_address);
				end
			end
			load_seen++;
		end
		if (!reset && alu_overflow) begin
			assert (ovf_seen < ovf_exp.size() && ovf_exp[ovf_seen] == store_seen) else begin
				errors++;
				$display("FAILED time %0t alu_overflow expected 0 actual 1", $time);
			end
			ovf_seen++;
		end
	end

	initial begin
		wait (prog_ready);
		repeat (prog_len * 4 + 100) @(posedge clk);
		$display("timeout: the program did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		void'($urandom(SEED));
		for (int i = 0; i < 1024; i++)
			imem[i] = '0;
		for (int i = 0; i < 4096; i++) begin
			dmem[i] = $urandom();
			model_mem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			model_reg[i] = '0;
		build_program();
		run_model();
		prog_ready = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// the last word is the halt jump
		while (im_address != pc_t'(prog_len - 1))
			@(posedge clk);
		repeat (20) @(posedge clk);
		assert (store_seen == exp_addr.size()) else begin
			errors++;
			$display("saw %0d stores, expected %0d", store_seen, exp_addr.size());
		end
		assert (load_seen == load_exp.size()) else begin
			errors++;
			$display("saw %0d loads, expected %0d", load_seen, load_exp.size());
		end
		assert (ovf_seen == ovf_exp.size()) else begin
			errors++;
			$display("saw %0d overflow events, expected %0d", ovf_seen, ovf_exp.size());
		end
		$display("error count: %0d", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire pipe_pkg::alu_op_t   op,
	input  wire [isa_pkg::xlen-1:0]  a,
	input  wire [isa_pkg::xlen-1:0]  b,
	output logic [isa_pkg::xlen-1:0] result,
	output logic                     overflow
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [4:0]      shamt;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] diff;

	assign shamt = b[4:0];
	assign sum   = a + b;
	assign diff  = a - b;

	always_comb begin
		overflow = 1'b0;
		case (op)
			alu_add: begin
				result = sum;
				// same signs in, other sign out
				overflow = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
			end
			alu_sub: begin
				result = diff;
				overflow = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);
			end
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_sll:    result = a << shamt;
			alu_srl:    result = a >> shamt;
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  wire          clk,
	input  wire          reset,
	input  wire [31:0]   instruction,
	output logic         alu_overflow,
	output logic         im_read,
	output isa_pkg::pc_t im_address,
	output logic         dm_read,
	output logic         dm_write,
	output logic [11:0]  dm_address,
	output logic [31:0]  dm_wdata,
	input  wire [31:0]   dm_rdata
);
	import isa_pkg::*;
	import pipe_pkg::*;

	instr_u  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	ctrl_t           dec_ctrl;
	logic [xlen-1:0] dec_imm;
	reg_addr_t       ra_addr;
	reg_addr_t       rb_addr;
	logic [xlen-1:0] ra_data;
	logic [xlen-1:0] rb_data;
	logic [xlen-1:0] ra_value;
	logic [xlen-1:0] rb_value;
	logic            stall;
	logic            flush;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_result;
	logic            alu_ovf;
	logic [xlen-1:0] mem_data;

	// only real sources go to the ports, so no false load-use stalls
	always_comb begin
		ra_addr = '0;
		rb_addr = '0;
		case (if_id.i.opcode)
			op_alu_r: begin
				ra_addr = if_id.r.ra;
				if (if_id.r.fn != fn_slli && if_id.r.fn != fn_srli)
					rb_addr = if_id.r.rb;
			end
			op_addi, op_ori, op_lwi: ra_addr = if_id.i.ra;
			// rt rides the second port for stores and compares
			op_swi, op_beq, op_bne: begin
				ra_addr = if_id.i.ra;
				rb_addr = if_id.i.rt;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush)
			if_id <= '0;
		else if (!stall)
			if_id <= im_read ? instruction : '0;
	end

	always_ff @(posedge clk) begin
		if (reset || stall) begin
			id_ex.ctrl <= ctrl_nop;
		end else begin
			id_ex <= '{ctrl: dec_ctrl, ra_value: ra_value, rb_value: rb_value,
				rt_value: rb_value, imm: dec_imm};
		end
	end

	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.rb_value;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.ctrl <= ctrl_nop;
			alu_overflow <= 1'b0;
		end else begin
			ex_mem <= '{ctrl: id_ex.ctrl, result: alu_result, store_data: id_ex.rt_value};
			// bubbles and load address sums carry no overflow
			alu_overflow <= alu_ovf && id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read;
		end
	end

	assign mem_data = ex_mem.ctrl.mem_read ? dm_rdata : ex_mem.result;

	always_ff @(posedge clk) begin
		if (reset)
			mem_wb.reg_write <= 1'b0;
		else
			mem_wb <= '{reg_write: ex_mem.ctrl.reg_write, dest: ex_mem.ctrl.dest, data: mem_data};
	end

	assign dm_read    = ex_mem.ctrl.mem_read;
	assign dm_write   = ex_mem.ctrl.mem_write;
	assign dm_address = ex_mem.result[11:0];
	assign dm_wdata   = ex_mem.store_data;

	fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.instr(if_id),
		.ra_value(ra_value),
		.rt_value(rb_value),
		.stall(stall),
		.pc(im_address),
		.fetch_valid(im_read),
		.flush(flush)
	);

	decoder u_decoder (
		.instr(if_id),
		.ctrl(dec_ctrl),
		.imm(dec_imm)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.we(mem_wb.reg_write),
		.wr_addr(mem_wb.dest),
		.wr_data(mem_wb.data),
		.ra_data(ra_data),
		.rb_data(rb_data)
	);

	forward u_forward (
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.ra_data(ra_data),
		.rb_data(rb_data),
		.ex_ctrl(id_ex.ctrl),
		.ex_result(alu_result),
		.mem_ctrl(ex_mem.ctrl),
		.mem_result(mem_data),
		.wb(mem_wb),
		.ra_value(ra_value),
		.rb_value(rb_value),
		.stall(stall)
	);

	alu u_alu (
		.op(id_ex.ctrl.alu_op),
		.a(id_ex.ra_value),
		.b(alu_b),
		.result(alu_result),
		.overflow(alu_ovf)
	);

endmodule

`default_nettype wire

// ==== verilog/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module decoder (
	input  wire isa_pkg::instr_u       instr,
	output pipe_pkg::ctrl_t            ctrl,
	output logic [isa_pkg::xlen-1:0]   imm
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0] imm_sext15;
	logic [xlen-1:0] imm_zext15;
	logic [xlen-1:0] imm_sext20;
	logic [xlen-1:0] imm_shamt;

	assign imm_sext15 = {{(xlen-15){instr.i.imm[14]}}, instr.i.imm};
	assign imm_zext15 = {{(xlen-15){1'b0}}, instr.i.imm};
	assign imm_sext20 = {{(xlen-20){instr[19]}}, instr[19:0]};
	assign imm_shamt  = {{(xlen-5){1'b0}}, instr.r.rb};

	always_comb begin
		ctrl = ctrl_nop;
		imm = '0;
		case (instr.i.opcode)
			op_alu_r: begin
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.r.rt;
				case (instr.r.fn)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or:  ctrl.alu_op = alu_or;
					fn_xor: ctrl.alu_op = alu_xor;
					fn_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.use_imm = 1'b1;
						imm = imm_shamt;
					end
					fn_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.use_imm = 1'b1;
						imm = imm_shamt;
					end
					default: ctrl = ctrl_nop;
				endcase
			end
			op_addi, op_ori, op_movi, op_lwi: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest = instr.i.rt;
				ctrl.mem_read = (instr.i.opcode == op_lwi);
				if (instr.i.opcode == op_ori) begin
					ctrl.alu_op = alu_or;
					imm = imm_zext15;
				end else if (instr.i.opcode == op_movi) begin
					ctrl.alu_op = alu_pass_b;
					imm = imm_sext20;
				end else begin
					ctrl.alu_op = alu_add;
					imm = imm_sext15;
				end
			end
			op_swi: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				imm = imm_sext15;
			end
			// branches and jumps finish in decode
			default: ctrl = ctrl_nop;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input  wire                      clk,
	input  wire                      reset,
	input  wire isa_pkg::instr_u     instr,
	input  wire [isa_pkg::xlen-1:0]  ra_value,
	input  wire [isa_pkg::xlen-1:0]  rt_value,
	input  wire                      stall,
	output isa_pkg::pc_t             pc,
	output logic                     fetch_valid,
	output logic                     flush
);
	import isa_pkg::*;

	logic            running;
	logic            hit;
	pc_t             decode_pc;
	pc_t             target;
	logic [xlen-1:0] br_off;
	logic [xlen-1:0] j_off;

	assign br_off = {{(xlen-14){instr.i.imm[13]}}, instr.i.imm[13:0]};
	assign j_off  = {{(xlen-24){instr[23]}}, instr[23:0]};

	always_comb begin
		case (instr.i.opcode)
			op_beq:  hit = (ra_value == rt_value);
			op_bne:  hit = (ra_value != rt_value);
			op_j:    hit = 1'b1;
			default: hit = 1'b0;
		endcase
	end

	// operands are not valid yet while a load-use stall is pending
	assign flush = hit & ~stall;
	assign target = decode_pc + ((instr.i.opcode == op_j) ? pc_t'(j_off) : pc_t'(br_off));

	// first cycle out of reset only arms the fetch
	assign fetch_valid = running & ~stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pc <= '0;
		end else begin
			running <= 1'b1;
			if (flush)
				pc <= target;
			else if (fetch_valid)
				pc <= pc + pc_t'(1);
		end
	end

	// address of the word now in decode
	always_ff @(posedge clk) begin
		if (fetch_valid)
			decode_pc <= pc;
	end

endmodule

`default_nettype wire

// ==== verilog/forward.sv ====
`timescale 1ns/1ns
`default_nettype none

module forward (
	input  wire isa_pkg::reg_addr_t  ra_addr,
	input  wire isa_pkg::reg_addr_t  rb_addr,
	input  wire [isa_pkg::xlen-1:0]  ra_data,
	input  wire [isa_pkg::xlen-1:0]  rb_data,
	input  wire pipe_pkg::ctrl_t     ex_ctrl,
	input  wire [isa_pkg::xlen-1:0]  ex_result,
	input  wire pipe_pkg::ctrl_t     mem_ctrl,
	input  wire [isa_pkg::xlen-1:0]  mem_result,
	input  wire pipe_pkg::mem_wb_t   wb,
	output logic [isa_pkg::xlen-1:0] ra_value,
	output logic [isa_pkg::xlen-1:0] rb_value,
	output logic                     stall
);
	import isa_pkg::*;

	// youngest producer wins and r0 never forwards
	function automatic logic [xlen-1:0] pick(
		input reg_addr_t       addr,
		input logic [xlen-1:0] rf_data
	);
		logic [xlen-1:0] value;
		value = rf_data;
		if (addr == '0)
			value = rf_data;
		else if (ex_ctrl.reg_write && !ex_ctrl.mem_read && ex_ctrl.dest == addr)
			value = ex_result;
		else if (mem_ctrl.reg_write && mem_ctrl.dest == addr)
			value = mem_result;
		else if (wb.reg_write && wb.dest == addr)
			value = wb.data;
		return value;
	endfunction

	always_comb begin
		ra_value = pick(ra_addr, ra_data);
		rb_value = pick(rb_addr, rb_data);
	end

	// load data is not there until memory
	assign stall = ex_ctrl.mem_read && ex_ctrl.dest != '0 &&
		(ex_ctrl.dest == ra_addr || ex_ctrl.dest == rb_addr);

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  wire                      clk,
	input  wire                      reset,
	input  wire isa_pkg::reg_addr_t  ra_addr,
	input  wire isa_pkg::reg_addr_t  rb_addr,
	input  wire                      we,
	input  wire isa_pkg::reg_addr_t  wr_addr,
	input  wire [isa_pkg::xlen-1:0]  wr_data,
	output logic [isa_pkg::xlen-1:0] ra_data,
	output logic [isa_pkg::xlen-1:0] rb_data
);
	import isa_pkg::*;

	logic [xlen-1:0] regs [32];

	// write in the same cycle wins over the stored value
	function automatic logic [xlen-1:0] read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (we && wr_addr == addr)
			return wr_data;
		return regs[addr];
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
	end

	always_ff @(posedge clk) begin
		if (reset)
			regs <= '{default: '0};
		else if (we && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

endmodule

`default_nettype wire
